// ==== Makefile ====
# Verilator build and run of the MBIST controller testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_mbist_top \
		-Mdir obj_dir -f flist.f
	./obj_dir/Vtb_mbist_top | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/mbist_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbist_addr_gen (
    input  logic                      clk,
    input  logic                      rstn,
    mbist_ctrl_if.addr                ctrl,
    output logic [mbist_pkg::ADDR_X-1:0] o_addr_x,
    output logic [mbist_pkg::ADDR_Y-1:0] o_addr_y
);
    import mbist_pkg::*;

    logic [ADDR_X-1:0] r_addr_x;
    logic [ADDR_X-1:0] next_x;
    logic [ADDR_Y-1:0] r_addr_y;
    logic [ADDR_Y-1:0] next_y;
    logic              r_inv_addr;
    t_addr_cmd         x_cmd;
    t_addr_cmd         y_cmd;
    logic              x_carry;
    logic              y_carry;

    // swaps INC and DEC, KEEP and CHG pass unchanged
    function automatic t_addr_cmd swap_dir(input t_addr_cmd cmd);
        return t_addr_cmd'({cmd[1], cmd[0] ^ cmd[1]});
    endfunction

    assign x_cmd = r_inv_addr ? swap_dir(ctrl.addr_x_cmd) : ctrl.addr_x_cmd;
    assign y_cmd = r_inv_addr ? swap_dir(ctrl.addr_y_cmd) : ctrl.addr_y_cmd;

    // --------------------
    // carries
    // --------------------
    // a CHG axis takes its direction from the other axis
    always_comb begin
        case (x_cmd)
            INC: x_carry = (r_addr_x == ADDR_X_MAX);
            DEC: x_carry = (r_addr_x == ADDR_X_MIN);
            CHG: x_carry = (y_cmd == INC) ? (r_addr_x == ADDR_X_MAX) :
                           (y_cmd == DEC) ? (r_addr_x == ADDR_X_MIN) : 1'b0;
            default: x_carry = 1'b0;
        endcase
        case (y_cmd)
            INC: y_carry = (r_addr_y == ADDR_Y_MAX);
            DEC: y_carry = (r_addr_y == ADDR_Y_MIN);
            CHG: y_carry = (x_cmd == INC) ? (r_addr_y == ADDR_Y_MAX) :
                           (x_cmd == DEC) ? (r_addr_y == ADDR_Y_MIN) : 1'b0;
            default: y_carry = 1'b0;
        endcase
    end

    assign ctrl.addr_x_carry = x_carry;
    assign ctrl.addr_y_carry = y_carry;

    // --------------------
    // next address
    // --------------------
    // bounds are the full range, so plain +1 / -1 wraps around
    always_comb begin
        case (x_cmd)
            INC: next_x = r_addr_x + 1'b1;
            DEC: next_x = r_addr_x - 1'b1;
            CHG: next_x = (y_cmd == INC && y_carry) ? r_addr_x + 1'b1 :
                          (y_cmd == DEC && y_carry) ? r_addr_x - 1'b1 : r_addr_x;
            default: next_x = r_addr_x;
        endcase
        case (y_cmd)
            INC: next_y = r_addr_y + 1'b1;
            DEC: next_y = r_addr_y - 1'b1;
            CHG: next_y = (x_cmd == INC && x_carry) ? r_addr_y + 1'b1 :
                          (x_cmd == DEC && x_carry) ? r_addr_y - 1'b1 : r_addr_y;
            default: next_y = r_addr_y;
        endcase
    end

    // a step that flips the order keeps the address, so the reversed
    // sequence starts from the last address of the previous pass
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_addr_x   <= '0;
            r_addr_y   <= '0;
            r_inv_addr <= 1'b0;
        end else if (ctrl.step) begin
            if (ctrl.toggle_addr) begin
                r_inv_addr <= ~r_inv_addr;
            end else begin
                r_addr_x <= next_x;
                r_addr_y <= next_y;
            end
        end
    end

    assign o_addr_x = r_addr_x;
    assign o_addr_y = r_addr_y;

endmodule

`default_nettype wire

// ==== design/mbist_bg_data_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbist_bg_data_gen (
    input  logic                          clk,
    input  logic                          rstn,
    mbist_ctrl_if.data                    ctrl,
    input  logic [mbist_pkg::ADDR_X-1:0]  i_addr_x,
    input  logic [mbist_pkg::ADDR_Y-1:0]  i_addr_y,
    output logic [mbist_pkg::BG_DATA-1:0] o_bg_data
);
    import mbist_pkg::*;

    logic [BG_DATA-1:0] r_data;
    logic [BG_DATA-1:0] next_data;
    logic               flip;

    // parity of the current address picks the pattern
    always_comb begin
        case (ctrl.bg_data_type)
            CS:      flip = i_addr_y[0];
            RS:      flip = i_addr_x[0];
            CB:      flip = i_addr_x[0] ^ i_addr_y[0];
            default: flip = 1'b0;
        endcase
    end

    // loop inversion is applied on top of the pattern
    assign next_data = (flip ^ ctrl.toggle_data) ? ~r_data : r_data;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_data <= '0;
        end else if (ctrl.step) begin
            r_data <= next_data;
        end
    end

    assign o_bg_data = r_data;

endmodule

`default_nettype wire

// ==== design/mbist_cmd_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbist_cmd_stage (
    input  logic                          clk,
    input  logic                          rstn,
    mbist_ctrl_if.cmd                     ctrl,
    input  logic [mbist_pkg::ADDR_X-1:0]  i_addr_x,
    input  logic [mbist_pkg::ADDR_Y-1:0]  i_addr_y,
    input  logic [mbist_pkg::BG_DATA-1:0] i_bg_data,
    input  logic                          i_ready,
    output logic                          o_can_step,
    output logic                          o_valid,
    output mbist_pkg::t_op_cmd            o_op,
    output logic [mbist_pkg::ADDR_X-1:0]  o_addr_x,
    output logic [mbist_pkg::ADDR_Y-1:0]  o_addr_y,
    output logic [mbist_pkg::BG_DATA-1:0] o_data
);
    import mbist_pkg::*;

    logic load;

    // stage is free when empty or when the held beat leaves this cycle
    assign o_can_step = ~o_valid | i_ready;

    assign load = ctrl.step & (ctrl.op != NOP);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        if (load) begin
            o_op     <= ctrl.op;
            o_addr_x <= i_addr_x;
            o_addr_y <= i_addr_y;
            o_data   <= (ctrl.bg_data_inv == INV) ? ~i_bg_data : i_bg_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/mbist_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mbist_ctrl_if;
    import mbist_pkg::*;

    // one pulse per executed instruction step
    logic          step;
    t_addr_cmd     addr_x_cmd;
    t_addr_cmd     addr_y_cmd;
    t_bg_data_type bg_data_type;
    t_dflt_inv     bg_data_inv;
    t_op_cmd       op;
    // loop event qualified by the inversion bits of the instruction
    logic          toggle_addr;
    logic          toggle_data;
    // axis carries returned to the completion logic
    logic          addr_x_carry;
    logic          addr_y_carry;

    modport seq (
        output step, addr_x_cmd, addr_y_cmd, bg_data_type, bg_data_inv, op,
        output toggle_addr, toggle_data,
        input  addr_x_carry, addr_y_carry
    );

    modport addr (
        input  step, addr_x_cmd, addr_y_cmd, toggle_addr,
        output addr_x_carry, addr_y_carry
    );

    modport data (input step, bg_data_type, toggle_data);

    modport cmd (input step, op, bg_data_inv);

endinterface

`default_nettype wire

// ==== design/mbist_pkg.sv ====
`default_nettype none

package mbist_pkg;

    // --------------------
    // sizes and limits
    // --------------------
    localparam int INST_NUM   = 8;
    localparam int INST_NUM_W = $clog2(INST_NUM);

    localparam int ADDR_X = 3;
    localparam int ADDR_Y = 3;

    localparam logic [ADDR_X-1:0] ADDR_X_MAX = '1;
    localparam logic [ADDR_X-1:0] ADDR_X_MIN = '0;
    localparam logic [ADDR_Y-1:0] ADDR_Y_MAX = '1;
    localparam logic [ADDR_Y-1:0] ADDR_Y_MIN = '0;

    localparam int BG_DATA  = 4;
    localparam int RPT_CNTR = 2;

    // repeat counter carries when it reaches this value
    localparam logic [RPT_CNTR-1:0] RC_MAX = RPT_CNTR'(3);

    // --------------------
    // command encodings
    // --------------------
    typedef enum logic [1:0] {
        NOP   = 2'd0,
        WRITE = 2'd1,
        READ  = 2'd2,
        RMW   = 2'd3
    } t_op_cmd;

    // bit 1 marks a counting command, so inverting the order only
    // needs bit 0 xor bit 1 to swap INC and DEC
    typedef enum logic [1:0] {
        KEEP = 2'd0,
        CHG  = 2'd1,
        INC  = 2'd2,
        DEC  = 2'd3
    } t_addr_cmd;

    typedef enum logic [1:0] {
        AL = 2'd0,
        CS = 2'd1,
        RS = 2'd2,
        CB = 2'd3
    } t_bg_data_type;

    typedef enum logic {
        DFLT = 1'b0,
        INV  = 1'b1
    } t_dflt_inv;

    typedef enum logic {
        RC_KEEP = 1'b0,
        RC_INC  = 1'b1
    } t_rpt_cntr_cmd;

    typedef enum logic [1:0] {
        NO_LOOP = 2'd0,
        REPEAT  = 2'd1,
        JUMP    = 2'd2
    } t_loop_mode;

    // --------------------
    // instruction word
    // --------------------
    typedef struct packed {
        logic [INST_NUM_W-1:0] jmp_to_inst;
        t_dflt_inv             inv_addr_seq;
        t_dflt_inv             inv_bg_data;
        t_loop_mode            loop_mode;
        logic                  cond_rc;
        logic                  cond_y;
        logic                  cond_x;
        t_rpt_cntr_cmd         rpt_cntr_cmd;
        t_addr_cmd             addr_y_cmd;
        t_addr_cmd             addr_x_cmd;
        t_dflt_inv             bg_data_inv;
        t_bg_data_type         bg_data_type;
        t_op_cmd               op;
    } t_inst_fields;

    localparam int INST_W = 20;

    // raw view for the scan chain, field view for decode
    typedef union packed {
        logic [INST_W-1:0] raw;
        t_inst_fields      f;
    } t_inst_word;

endpackage

`default_nettype wire

// ==== design/mbist_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbist_sequencer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_shift_mode,
    input  logic            i_si,
    input  logic            i_mbist_run,
    input  logic            i_can_step,
    output logic            o_so,
    output logic            o_end_of_prog,
    mbist_ctrl_if.seq       ctrl
);
    import mbist_pkg::*;

    t_inst_word            r_store [INST_NUM];
    t_inst_word            cur;
    logic [INST_NUM_W-1:0] r_inst_ptr;
    logic [INST_NUM_W-1:0] next_ptr;
    logic [INST_NUM-1:0]   r_loop;
    logic [INST_NUM-1:0]   next_loop;
    logic [RPT_CNTR-1:0]   r_rpt_cntr;
    logic                  r_done;
    logic                  r_eop;

    logic step;
    logic rc_carry;
    logic complete;
    logic jmp_en;
    logic loop_event;
    logic finish;

    // --------------------
    // instruction store
    // --------------------
    // one long chain, slot 0 bit 0 in, top bit of the last slot out
    always_ff @(posedge clk) begin
        if (i_shift_mode) begin
            r_store[0].raw <= {r_store[0].raw[INST_W-2:0], i_si};
            for (int i = 1; i < INST_NUM; i++) begin
                r_store[i].raw <= {r_store[i].raw[INST_W-2:0], r_store[i-1].raw[INST_W-1]};
            end
        end
    end

    assign o_so = r_store[INST_NUM-1].raw[INST_W-1];

    assign cur = r_store[r_inst_ptr];

    // --------------------
    // completion and flow
    // --------------------
    assign step = i_mbist_run & ~i_shift_mode & ~r_done & i_can_step;

    assign rc_carry = (r_rpt_cntr == RC_MAX);

    // unselected conditions count as met
    assign complete = (~cur.f.cond_x  | ctrl.addr_x_carry) &
                      (~cur.f.cond_y  | ctrl.addr_y_carry) &
                      (~cur.f.cond_rc | rc_carry);

    assign jmp_en = ((cur.f.loop_mode == REPEAT) & complete & ~r_loop[r_inst_ptr]) |
                    ((cur.f.loop_mode == JUMP) & ~complete);

    assign loop_event = jmp_en | ((cur.f.loop_mode == REPEAT) & complete);

    assign finish = (r_inst_ptr == INST_NUM_W'(INST_NUM - 1)) & complete & ~jmp_en;

    always_comb begin
        if (jmp_en) begin
            next_ptr = cur.f.jmp_to_inst;
        end else if (complete) begin
            next_ptr = r_inst_ptr + 1'b1;
        end else begin
            next_ptr = r_inst_ptr;
        end
    end

    // loop bits of slots already left behind are cleared
    always_comb begin
        for (int i = 0; i < INST_NUM; i++) begin
            if (INST_NUM_W'(i) < r_inst_ptr) begin
                next_loop[i] = 1'b0;
            end else begin
                next_loop[i] = r_loop[i];
            end
        end
        if (cur.f.loop_mode == REPEAT && complete) begin
            next_loop[r_inst_ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            r_inst_ptr <= '0;
            r_loop     <= '0;
            r_rpt_cntr <= '0;
            r_done     <= 1'b0;
            r_eop      <= 1'b0;
        end else begin
            r_eop <= step & finish;
            if (step) begin
                r_inst_ptr <= next_ptr;
                r_loop     <= next_loop;
                if (cur.f.rpt_cntr_cmd == RC_INC) begin
                    r_rpt_cntr <= r_rpt_cntr + 1'b1;
                end
                if (finish) begin
                    r_done <= 1'b1;
                end
            end
        end
    end

    assign o_end_of_prog = r_eop;

    // --------------------
    // step control out
    // --------------------
    assign ctrl.step         = step;
    assign ctrl.addr_x_cmd   = cur.f.addr_x_cmd;
    assign ctrl.addr_y_cmd   = cur.f.addr_y_cmd;
    assign ctrl.bg_data_type = cur.f.bg_data_type;
    assign ctrl.bg_data_inv  = cur.f.bg_data_inv;
    assign ctrl.op           = cur.f.op;
    assign ctrl.toggle_addr  = loop_event & (cur.f.inv_addr_seq == INV);
    assign ctrl.toggle_data  = loop_event & (cur.f.inv_bg_data == INV);

endmodule

`default_nettype wire

// ==== design/mbist_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbist_top (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_shift_mode,
    input  logic                          i_si,
    output logic                          o_so,
    input  logic                          i_mbist_run,
    input  logic                          i_ready,
    output logic                          o_valid,
    output mbist_pkg::t_op_cmd            o_op,
    output logic [mbist_pkg::ADDR_X-1:0]  o_addr_x,
    output logic [mbist_pkg::ADDR_Y-1:0]  o_addr_y,
    output logic [mbist_pkg::BG_DATA-1:0] o_data,
    output logic                          o_end_of_prog
);
    import mbist_pkg::*;

    logic [ADDR_X-1:0]  addr_x;
    logic [ADDR_Y-1:0]  addr_y;
    logic [BG_DATA-1:0] bg_data;
    logic               can_step;

    mbist_ctrl_if u_ctrl_if ();

    mbist_sequencer u_sequencer (
        .clk           (clk),
        .rstn          (rstn),
        .i_shift_mode  (i_shift_mode),
        .i_si          (i_si),
        .i_mbist_run   (i_mbist_run),
        .i_can_step    (can_step),
        .o_so          (o_so),
        .o_end_of_prog (o_end_of_prog),
        .ctrl          (u_ctrl_if.seq)
    );

    mbist_addr_gen u_addr_gen (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (u_ctrl_if.addr),
        .o_addr_x (addr_x),
        .o_addr_y (addr_y)
    );

    mbist_bg_data_gen u_bg_data_gen (
        .clk       (clk),
        .rstn      (rstn),
        .ctrl      (u_ctrl_if.data),
        .i_addr_x  (addr_x),
        .i_addr_y  (addr_y),
        .o_bg_data (bg_data)
    );

    mbist_cmd_stage u_cmd_stage (
        .clk        (clk),
        .rstn       (rstn),
        .ctrl       (u_ctrl_if.cmd),
        .i_addr_x   (addr_x),
        .i_addr_y   (addr_y),
        .i_bg_data  (bg_data),
        .i_ready    (i_ready),
        .o_can_step (can_step),
        .o_valid    (o_valid),
        .o_op       (o_op),
        .o_addr_x   (o_addr_x),
        .o_addr_y   (o_addr_y),
        .o_data     (o_data)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
design/mbist_pkg.sv
design/mbist_ctrl_if.sv
design/mbist_sequencer.sv
design/mbist_addr_gen.sv
design/mbist_bg_data_gen.sv
design/mbist_cmd_stage.sv
design/mbist_top.sv
tb/mbist_top_chk.sv
tb/tb_mbist_top.sv

// ==== tb/mbist_top_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbist_top_chk (
    input logic                          clk,
    input logic                          rstn,
    input logic                          i_shift_mode,
    input logic                          i_ready,
    input logic                          i_valid,
    input mbist_pkg::t_op_cmd            i_op,
    input logic [mbist_pkg::ADDR_X-1:0]  i_addr_x,
    input logic [mbist_pkg::ADDR_Y-1:0]  i_addr_y,
    input logic [mbist_pkg::BG_DATA-1:0] i_data,
    input logic                          i_end_of_prog
);

    // --------------------
    // output handshake
    // --------------------
    // a waiting beat keeps its payload until taken
    a_beat_stable: assert property (@(posedge clk) disable iff (!rstn)
        i_valid && !i_ready |=> i_valid && $stable(i_op) && $stable(i_addr_x) &&
            $stable(i_addr_y) && $stable(i_data))
        else $error("beat changed while waiting for ready");

    // no new beat while the store is shifting
    a_no_valid_in_shift: assert property (@(posedge clk) disable iff (!rstn)
        i_shift_mode && !i_valid |=> !i_valid)
        else $error("valid raised during shift mode");

    // --------------------
    // control outputs
    // --------------------
    a_eop_pulse: assert property (@(posedge clk) disable iff (!rstn)
        i_end_of_prog |=> !i_end_of_prog)
        else $error("end of program longer than one cycle");

    a_reset_idle: assert property (@(posedge clk)
        $rose(rstn) |-> !i_valid && !i_end_of_prog)
        else $error("outputs active right after reset");

endmodule

bind mbist_top mbist_top_chk u_chk (
    .clk           (clk),
    .rstn          (rstn),
    .i_shift_mode  (i_shift_mode),
    .i_ready       (i_ready),
    .i_valid       (o_valid),
    .i_op          (o_op),
    .i_addr_x      (o_addr_x),
    .i_addr_y      (o_addr_y),
    .i_data        (o_data),
    .i_end_of_prog (o_end_of_prog)
);

`default_nettype wire

// ==== tb/tb_mbist_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mbist_top;
    import mbist_pkg::*;

    logic               clk;
    logic               rstn;
    logic               i_shift_mode;
    logic               i_si;
    logic               i_mbist_run;
    logic               i_ready;
    logic               o_so;
    logic               o_valid;
    t_op_cmd            o_op;
    logic [ADDR_X-1:0]  o_addr_x;
    logic [ADDR_Y-1:0]  o_addr_y;
    logic [BG_DATA-1:0] o_data;
    logic               o_end_of_prog;

    int seed = 89211;
    int errors;
    int checks;
    int cycles;
    int cycle_limit = 64;

    t_inst_word         prog [INST_NUM];
    t_op_cmd            exp_op [$];
    logic [ADDR_X-1:0]  exp_x [$];
    logic [ADDR_Y-1:0]  exp_y [$];
    logic [BG_DATA-1:0] exp_d [$];

    mbist_top u_mbist_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // watchdog whose limit each test moves forward
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout, no end of test after %0d cycles", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_op(input string name, input t_op_cmd got, input t_op_cmd exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %s exp %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_addr_x(input string name, input logic [ADDR_X-1:0] got,
                                input logic [ADDR_X-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr_y(input string name, input logic [ADDR_Y-1:0] got,
                                input logic [ADDR_Y-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [BG_DATA-1:0] got,
                              input logic [BG_DATA-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    // --------------------
    // program helpers
    // --------------------
    task automatic clear_prog();
        for (int i = 0; i < INST_NUM; i++) begin
            prog[i].raw = '0;
        end
    endtask

    // full X/Y sweep in row order that completes when both axes carry
    task automatic set_sweep(input int slot, input t_op_cmd op, input t_bg_data_type bg,
                             input t_dflt_inv dinv);
        prog[slot].f.addr_x_cmd   = INC;
        prog[slot].f.addr_y_cmd   = CHG;
        prog[slot].f.cond_x       = 1'b1;
        prog[slot].f.cond_y       = 1'b1;
        prog[slot].f.op           = op;
        prog[slot].f.bg_data_type = bg;
        prog[slot].f.bg_data_inv  = dinv;
    endtask

    // slot 0 ends up in the low bits and the last slot on top
    function automatic logic [INST_NUM*INST_W-1:0] pack_prog();
        logic [INST_NUM*INST_W-1:0] flat;
        flat = '0;
        for (int i = INST_NUM - 1; i >= 0; i--) begin
            flat = {flat[INST_NUM*INST_W-INST_W-1:0], prog[i].raw};
        end
        return flat;
    endfunction

    // run is held high while shifting and no step may start
    task automatic load_prog();
        logic [INST_NUM*INST_W-1:0] flat;
        flat = pack_prog();
        for (int k = 0; k < INST_NUM * INST_W; k++) begin
            @(negedge clk);
            i_shift_mode = 1'b1;
            i_mbist_run  = 1'b1;
            i_si         = flat[INST_NUM*INST_W-1];
            flat         = {flat[INST_NUM*INST_W-2:0], flat[INST_NUM*INST_W-1]};
        end
        @(negedge clk);
        i_shift_mode = 1'b0;
        i_mbist_run  = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rstn         = 1'b0;
        i_mbist_run  = 1'b0;
        i_shift_mode = 1'b0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
    endtask

    // four cycles per step plus reset and two full scan passes
    task automatic budget(input int steps);
        cycle_limit = cycles + 4 * steps + 2 * INST_NUM * INST_W + 48;
    endtask

    task automatic clear_expect();
        exp_op.delete();
        exp_x.delete();
        exp_y.delete();
        exp_d.delete();
    endtask

    task automatic push_beat(input t_op_cmd op, input logic [ADDR_X-1:0] x,
                             input logic [ADDR_Y-1:0] y, input logic [BG_DATA-1:0] d);
        exp_op.push_back(op);
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_d.push_back(d);
    endtask

    // --------------------
    // reference model
    // --------------------
    function automatic t_addr_cmd order_cmd(input t_addr_cmd c, input bit inv);
        if (inv && c == INC) return DEC;
        if (inv && c == DEC) return INC;
        return c;
    endfunction

    // CHG follows the direction of the other axis
    function automatic t_addr_cmd eff_dir(input t_addr_cmd own, input t_addr_cmd other);
        return (own == CHG) ? other : own;
    endfunction

    function automatic bit at_end(input t_addr_cmd dir, input int pos, input int max);
        return (dir == INC && pos == max) || (dir == DEC && pos == 0);
    endfunction

    function automatic int move(input t_addr_cmd dir, input int pos, input int max);
        if (dir == INC) return (pos == max) ? 0 : pos + 1;
        if (dir == DEC) return (pos == 0) ? max : pos - 1;
        return pos;
    endfunction

    task automatic model_prog(output int steps);
        logic [INST_NUM_W-1:0] ptr;
        logic [INST_NUM-1:0]   loopb;
        logic [RPT_CNTR-1:0]   rc;
        logic [BG_DATA-1:0]    d;
        t_inst_fields          f;
        t_addr_cmd             xd;
        t_addr_cmd             yd;
        int                    x;
        int                    y;
        bit                    inv;
        bit                    xcar;
        bit                    ycar;
        bit                    comp;
        bit                    jmp;
        bit                    lev;
        bit                    flip;
        bit                    done;
        clear_expect();
        ptr   = '0;
        loopb = '0;
        rc    = '0;
        d     = '0;
        x     = 0;
        y     = 0;
        inv   = 1'b0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4096) begin
            f    = prog[ptr].f;
            xd   = order_cmd(f.addr_x_cmd, inv);
            yd   = order_cmd(f.addr_y_cmd, inv);
            xcar = at_end(eff_dir(xd, yd), x, int'(ADDR_X_MAX));
            ycar = at_end(eff_dir(yd, xd), y, int'(ADDR_Y_MAX));
            comp = (!f.cond_x || xcar) && (!f.cond_y || ycar) &&
                   (!f.cond_rc || rc == RC_MAX);
            jmp  = (f.loop_mode == REPEAT && comp && !loopb[ptr]) ||
                   (f.loop_mode == JUMP && !comp);
            lev  = jmp || (f.loop_mode == REPEAT && comp);
            if (f.op != NOP) begin
                push_beat(f.op, ADDR_X'(x), ADDR_Y'(y), (f.bg_data_inv == INV) ? ~d : d);
            end
            case (f.bg_data_type)
                CS:      flip = y[0];
                RS:      flip = x[0];
                CB:      flip = x[0] ^ y[0];
                default: flip = 1'b0;
            endcase
            if (flip ^ (lev && f.inv_bg_data == INV)) begin
                d = ~d;
            end
            // an order flip holds the address for that step
            if (lev && f.inv_addr_seq == INV) begin
                inv = !inv;
            end else begin
                x = move((xd == CHG) ? (ycar ? yd : KEEP) : xd, x, int'(ADDR_X_MAX));
                y = move((yd == CHG) ? (xcar ? xd : KEEP) : yd, y, int'(ADDR_Y_MAX));
            end
            if (f.rpt_cntr_cmd == RC_INC) begin
                rc = rc + 1'b1;
            end
            for (int i = 0; i < INST_NUM; i++) begin
                if (i < int'(ptr)) begin
                    loopb[i] = 1'b0;
                end
            end
            if (f.loop_mode == REPEAT && comp) begin
                loopb[ptr] = 1'b1;
            end
            if (jmp) begin
                ptr = f.jmp_to_inst;
            end else if (comp && ptr == INST_NUM_W'(INST_NUM - 1)) begin
                done = 1'b1;
            end else if (comp) begin
                ptr = ptr + 1'b1;
            end
            steps++;
        end
        if (!done) begin
            errors++;
            $display("ERROR: reference model found no end of program");
        end
    endtask

    // --------------------
    // run and collect beats
    // --------------------
    task automatic run_and_check(input bit rnd_ready);
        int idx;
        bit eop_seen;
        idx      = 0;
        eop_seen = 1'b0;
        @(negedge clk);
        i_mbist_run = 1'b1;
        while (!eop_seen || idx < exp_op.size()) begin
            @(negedge clk);
            i_ready = rnd_ready ? 1'($random(seed)) : 1'b1;
            // at the end pulse only the last beat may still be waiting
            if (o_end_of_prog) begin
                eop_seen = 1'b1;
                if (idx + int'(o_valid) != exp_op.size()) begin
                    errors++;
                    $display("ERROR: t=%0t end of program after %0d of %0d beats",
                             $time, idx + int'(o_valid), exp_op.size());
                end
            end
            if (o_valid && i_ready) begin
                if (idx < exp_op.size()) begin
                    check_op("o_op", o_op, exp_op[idx]);
                    check_addr_x("o_addr_x", o_addr_x, exp_x[idx]);
                    check_addr_y("o_addr_y", o_addr_y, exp_y[idx]);
                    check_data("o_data", o_data, exp_d[idx]);
                end else begin
                    errors++;
                    $display("ERROR: t=%0t more beats than the %0d expected",
                             $time, exp_op.size());
                end
                idx++;
            end
        end
        i_ready = 1'b1;
        // no beat and no end pulse may follow a finished program
        repeat (8) begin
            @(negedge clk);
            check_bit("o_valid", o_valid, 1'b0);
            check_bit("o_end_of_prog", o_end_of_prog, 1'b0);
        end
        i_mbist_run = 1'b0;
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic scan_round_trip();
        logic [INST_NUM*INST_W-1:0] flat;
        for (int i = 0; i < INST_NUM; i++) begin
            prog[i].raw = INST_W'($random(seed));
        end
        budget(0);
        apply_reset();
        load_prog();
        flat = pack_prog();
        // shift out and feed the same bits back in
        for (int k = 0; k < INST_NUM * INST_W; k++) begin
            @(negedge clk);
            i_shift_mode = 1'b1;
            check_bit("o_so", o_so, flat[INST_NUM*INST_W-1]);
            i_si = flat[INST_NUM*INST_W-1];
            flat = {flat[INST_NUM*INST_W-2:0], flat[INST_NUM*INST_W-1]};
        end
        @(negedge clk);
        i_shift_mode = 1'b0;
    endtask

    task automatic write_sweep(input bit rnd_ready);
        clear_prog();
        set_sweep(0, WRITE, AL, DFLT);
        clear_expect();
        for (int y = 0; y <= int'(ADDR_Y_MAX); y++) begin
            for (int x = 0; x <= int'(ADDR_X_MAX); x++) begin
                push_beat(WRITE, ADDR_X'(x), ADDR_Y'(y), '0);
            end
        end
        // one step per sweep address and one per NOP slot
        budget(exp_op.size() + INST_NUM - 1);
        apply_reset();
        load_prog();
        run_and_check(rnd_ready);
    endtask

    task automatic run_model_test(input bit rnd_ready);
        int steps;
        model_prog(steps);
        budget(steps);
        apply_reset();
        load_prog();
        run_and_check(rnd_ready);
    endtask

    task automatic repeat_inversion();
        clear_prog();
        set_sweep(0, WRITE, AL, DFLT);
        prog[0].f.loop_mode    = REPEAT;
        prog[0].f.jmp_to_inst  = '0;
        prog[0].f.inv_addr_seq = INV;
        prog[0].f.inv_bg_data  = INV;
        set_sweep(1, READ, AL, DFLT);
        run_model_test(1'b0);
    endtask

    task automatic backgrounds();
        clear_prog();
        set_sweep(0, WRITE, CS, INV);
        set_sweep(1, READ, RS, INV);
        set_sweep(2, READ, CB, DFLT);
        run_model_test(1'b0);
    endtask

    task automatic counter_loop();
        clear_prog();
        prog[0].f.op           = READ;
        prog[0].f.addr_x_cmd   = INC;
        prog[0].f.rpt_cntr_cmd = RC_INC;
        prog[0].f.cond_rc      = 1'b1;
        prog[0].f.loop_mode    = JUMP;
        prog[0].f.jmp_to_inst  = '0;
        prog[1].f.op           = WRITE;
        run_model_test(1'b0);
    endtask

    initial begin
        rstn         = 1'b0;
        i_shift_mode = 1'b0;
        i_si         = 1'b0;
        i_mbist_run  = 1'b0;
        i_ready      = 1'b1;
        errors       = 0;
        checks       = 0;
        scan_round_trip();
        write_sweep(1'b0);
        write_sweep(1'b1);
        repeat_inversion();
        backgrounds();
        counter_loop();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
